// ==== axi_mem_pkg.sv ====
// Shared widths, AXI channel structs and response and atomic codes for the ATOP memory target.
package axi_mem_pkg;

  // Width of the AXI transaction ID.
  localparam int unsigned IdWidth = 4;
  // Word address width; one address selects one 32-bit word.
  localparam int unsigned AddrWidth = 8;
  // Data bus width in bits.
  localparam int unsigned DataWidth = 32;
  // One strobe bit per data byte.
  localparam int unsigned StrbWidth = DataWidth / 8;
  // Number of words in the storage array.
  localparam int unsigned MemDepth = 256;
  // Most write bursts that may be outstanding between the filter and the memory.
  localparam int unsigned MaxWriteTxns = 4;

  // Plain vector types for the fields that carry a meaning.
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [7:0]           len_t;
  typedef logic [5:0]           atop_t;
  typedef logic [1:0]           resp_t;

  // Response codes on B and R.
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  // Class of an atomic operation, taken from atop[5:4].
  localparam logic [1:0] AtopNone    = 2'b00;
  localparam logic [1:0] AtopStore   = 2'b01;
  localparam logic [1:0] AtopLoad    = 2'b10;
  localparam logic [1:0] AtopSwapCmp = 2'b11;

  // Write address channel payload.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    atop_t atop;
  } aw_chan_t;

  // Write data channel payload.
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Write response channel payload.
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // Read address channel payload.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  // Read data channel payload.
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // Everything a manager drives on one AXI port.
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything a subordinate drives on one AXI port.
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_rsp_t;

endpackage

// ==== axi_atop_filter.sv ====
// Strips atomic bursts from an AXI stream and answers them with SLVERR on B and, if owed, on R.
`timescale 1ns/1ps

module axi_atop_filter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  axi_mem_pkg::axi_req_t slv_req_i,
  output axi_mem_pkg::axi_rsp_t slv_rsp_o,
  output axi_mem_pkg::axi_req_t mst_req_o,
  input  axi_mem_pkg::axi_rsp_t mst_rsp_i
);
  import axi_mem_pkg::*;

  // Counter of downstream write bursts whose AW has passed but whose last W has not.
  typedef logic [$clog2(MaxWriteTxns+1)-1:0] cnt_t;

  typedef enum logic [2:0] {
    w_feedthrough,
    w_block_aw,
    w_absorb_w,
    w_inject_b,
    w_wait_r
  } w_state_t;

  typedef enum logic {
    r_feedthrough,
    r_inject
  } r_state_t;

  w_state_t w_state_d, w_state_q;
  r_state_t r_state_d, r_state_q;
  cnt_t     w_cnt_d, w_cnt_q;
  id_t      id_d, id_q;
  len_t     r_beats_d, r_beats_q;

  // One-entry command register for an owed R burst.
  logic r_cmd_valid_d, r_cmd_valid_q;
  len_t r_cmd_len_d, r_cmd_len_q;
  logic r_cmd_push, r_cmd_pop;

  // High while a downstream R burst has sent some beats but not its last one.
  logic r_busy_d, r_busy_q;
  logic r_can_start;

  // Channel signals as driven by the two control blocks.
  aw_chan_t mst_aw;
  logic     mst_aw_valid, slv_aw_ready;
  logic     mst_w_valid, slv_w_ready;
  logic     mst_b_ready, slv_b_valid;
  b_chan_t  slv_b;
  logic     mst_r_ready, slv_r_valid;
  r_chan_t  slv_r;

  // Write side: AW, W and B.
  always_comb begin
    mst_aw_valid = 1'b0;
    slv_aw_ready = 1'b0;
    mst_w_valid  = 1'b0;
    slv_w_ready  = 1'b0;
    // Downstream write responses pass unless an error response is being injected.
    mst_b_ready  = slv_req_i.b_ready;
    slv_b_valid  = mst_rsp_i.b_valid;
    slv_b        = mst_rsp_i.b;
    id_d         = id_q;
    r_cmd_push   = 1'b0;
    w_state_d    = w_state_q;

    unique case (w_state_q)
      w_feedthrough: begin
        // AWs pass while the outstanding limit has room.
        if (w_cnt_q < cnt_t'(MaxWriteTxns)) begin
          mst_aw_valid = slv_req_i.aw_valid;
          slv_aw_ready = mst_rsp_i.aw_ready;
        end
        // W beats only pass once their AW is known to be an ordinary one.
        if (w_cnt_q != '0) begin
          mst_w_valid = slv_req_i.w_valid;
          slv_w_ready = mst_rsp_i.w_ready;
        end
        if (slv_req_i.aw_valid && slv_req_i.aw.atop[5:4] != AtopNone) begin
          // An atomic AW is taken here and never reaches the memory.
          mst_aw_valid = 1'b0;
          slv_aw_ready = 1'b1;
          id_d         = slv_req_i.aw.id;
          // Loads, swaps and compares also owe an R burst.
          if (slv_req_i.aw.atop[5:4] != AtopStore) begin
            r_cmd_push = 1'b1;
          end
          if (w_cnt_q != '0) begin
            // Earlier bursts still own the W channel.
            w_state_d = w_block_aw;
          end else begin
            mst_w_valid = 1'b0;
            slv_w_ready = 1'b1;
            if (slv_req_i.w_valid && slv_req_i.w.last) begin
              w_state_d = w_inject_b;
            end else begin
              w_state_d = w_absorb_w;
            end
          end
        end
      end

      w_block_aw: begin
        if (w_cnt_q != '0) begin
          mst_w_valid = slv_req_i.w_valid;
          slv_w_ready = mst_rsp_i.w_ready;
        end else begin
          // The W channel is free, so the atomic data is next.
          slv_w_ready = 1'b1;
          if (slv_req_i.w_valid && slv_req_i.w.last) begin
            w_state_d = w_inject_b;
          end else begin
            w_state_d = w_absorb_w;
          end
        end
      end

      w_absorb_w: begin
        slv_w_ready = 1'b1;
        if (slv_req_i.w_valid && slv_req_i.w.last) begin
          w_state_d = w_inject_b;
        end
      end

      w_inject_b: begin
        // Downstream B waits while the error response is held.
        mst_b_ready = 1'b0;
        slv_b_valid = 1'b1;
        slv_b.id    = id_q;
        slv_b.resp  = RespSlvErr;
        if (slv_req_i.b_ready) begin
          if (r_cmd_valid_q && !r_cmd_pop) begin
            w_state_d = w_wait_r;
          end else begin
            w_state_d = w_feedthrough;
          end
        end
      end

      w_wait_r: begin
        // New AWs wait until the owed R burst has gone out.
        if (!r_cmd_valid_q) begin
          w_state_d = w_feedthrough;
        end
      end

      default: w_state_d = w_feedthrough;
    endcase
  end

  // Payload passes straight through, with atop forced to zero downstream.
  always_comb begin
    mst_aw      = slv_req_i.aw;
    mst_aw.atop = '0;
  end

  // Outstanding downstream write bursts.
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (mst_aw_valid && mst_rsp_i.aw_ready) begin
      w_cnt_d = w_cnt_d + cnt_t'(1);
    end
    if (mst_w_valid && mst_rsp_i.w_ready && slv_req_i.w.last) begin
      w_cnt_d = w_cnt_d - cnt_t'(1);
    end
  end

  // Injection may start only at a burst boundary of the downstream R stream.
  // A beat held without a transfer would otherwise change under valid.
  assign r_can_start = !r_busy_q &&
                       (!mst_rsp_i.r_valid || (slv_req_i.r_ready && mst_rsp_i.r.last));

  // Read side: R feed-through or injected SLVERR beats.
  always_comb begin
    slv_r       = mst_rsp_i.r;
    slv_r_valid = mst_rsp_i.r_valid;
    mst_r_ready = slv_req_i.r_ready;
    r_cmd_pop   = 1'b0;
    r_beats_d   = r_beats_q;
    r_state_d   = r_state_q;

    unique case (r_state_q)
      r_feedthrough: begin
        // A command pushed this cycle is taken at once, so beats start on the next cycle.
        if ((r_cmd_valid_q || r_cmd_push) && r_can_start) begin
          r_beats_d = r_cmd_valid_q ? r_cmd_len_q : slv_req_i.aw.len;
          r_state_d = r_inject;
        end
      end

      r_inject: begin
        mst_r_ready = 1'b0;
        slv_r_valid = 1'b1;
        slv_r       = '0;
        slv_r.id    = id_q;
        slv_r.resp  = RespSlvErr;
        slv_r.last  = (r_beats_q == '0);
        if (slv_req_i.r_ready) begin
          if (r_beats_q == '0) begin
            r_cmd_pop = 1'b1;
            r_state_d = r_feedthrough;
          end else begin
            r_beats_d = r_beats_q - len_t'(1);
          end
        end
      end

      default: r_state_d = r_feedthrough;
    endcase
  end

  // Track bursts in flight on the downstream R channel.
  always_comb begin
    r_busy_d = r_busy_q;
    if (mst_rsp_i.r_valid && mst_r_ready) begin
      r_busy_d = !mst_rsp_i.r.last;
    end
  end

  // Command register, filled on an atomic AW and emptied after the last injected beat.
  always_comb begin
    r_cmd_valid_d = r_cmd_valid_q;
    r_cmd_len_d   = r_cmd_len_q;
    if (r_cmd_push) begin
      r_cmd_valid_d = 1'b1;
      r_cmd_len_d   = slv_req_i.aw.len;
    end
    if (r_cmd_pop) begin
      r_cmd_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q     <= w_feedthrough;
      r_state_q     <= r_feedthrough;
      w_cnt_q       <= '0;
      r_beats_q     <= '0;
      r_cmd_valid_q <= 1'b0;
      r_busy_q      <= 1'b0;
    end else begin
      w_state_q     <= w_state_d;
      r_state_q     <= r_state_d;
      w_cnt_q       <= w_cnt_d;
      r_beats_q     <= r_beats_d;
      r_cmd_valid_q <= r_cmd_valid_d;
      r_busy_q      <= r_busy_d;
    end
  end

  // Atomic ID and owed R burst length, loaded when an atomic AW is absorbed.
  always_ff @(posedge clk_i) begin
    id_q        <= id_d;
    r_cmd_len_q <= r_cmd_len_d;
  end

  // AR needs no filtering and passes through unchanged.
  assign mst_req_o = '{
    aw:       mst_aw,
    aw_valid: mst_aw_valid,
    w:        slv_req_i.w,
    w_valid:  mst_w_valid,
    b_ready:  mst_b_ready,
    ar:       slv_req_i.ar,
    ar_valid: slv_req_i.ar_valid,
    r_ready:  mst_r_ready
  };

  assign slv_rsp_o = '{
    aw_ready: slv_aw_ready,
    w_ready:  slv_w_ready,
    b:        slv_b,
    b_valid:  slv_b_valid,
    ar_ready: mst_rsp_i.ar_ready,
    r:        slv_r,
    r_valid:  slv_r_valid
  };

endmodule

// ==== mem_write_engine.sv ====
// Accepts one AXI write burst at a time, writes its beats into the array and answers OKAY on B.
`timescale 1ns/1ps

module mem_write_engine (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  axi_mem_pkg::aw_chan_t aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_mem_pkg::w_chan_t  w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output axi_mem_pkg::b_chan_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output logic                  wr_en_o,
  output axi_mem_pkg::addr_t    wr_addr_o,
  output axi_mem_pkg::data_t    wr_data_o,
  output axi_mem_pkg::strb_t    wr_strb_o
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_resp
  } state_t;

  state_t state_d, state_q;
  id_t    id_q;
  addr_t  addr_q;
  logic   aw_fire, w_fire;

  assign aw_ready_o = (state_q == st_idle);
  assign w_ready_o  = (state_q == st_data);
  assign aw_fire    = aw_valid_i && aw_ready_o;
  assign w_fire     = w_valid_i && w_ready_o;

  // Each accepted beat goes to the array in the cycle of its transfer.
  assign wr_en_o   = w_fire;
  assign wr_addr_o = addr_q;
  assign wr_data_o = w_i.data;
  assign wr_strb_o = w_i.strb;

  // The response is held until the manager takes it.
  assign b_valid_o = (state_q == st_resp);
  assign b_o.id    = id_q;
  assign b_o.resp  = RespOkay;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: if (aw_fire) state_d = st_data;
      st_data: if (w_fire && w_i.last) state_d = st_resp;
      st_resp: if (b_ready_i) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // The address wraps at the array end, since MemDepth fills addr_t exactly.
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      id_q   <= aw_i.id;
      addr_q <= aw_i.addr;
    end else if (w_fire) begin
      addr_q <= addr_q + addr_t'(1);
    end
  end

endmodule

// ==== mem_read_engine.sv ====
// Serves one AXI read burst at a time, one beat per cycle, from the combinational array port.
`timescale 1ns/1ps

module mem_read_engine (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  axi_mem_pkg::ar_chan_t ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output axi_mem_pkg::r_chan_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output axi_mem_pkg::addr_t    rd_addr_o,
  input  axi_mem_pkg::data_t    rd_data_i
);
  import axi_mem_pkg::*;

  typedef enum logic {
    st_idle,
    st_burst
  } state_t;

  state_t state_q;
  id_t    id_q;
  addr_t  addr_q;
  len_t   len_q;
  len_t   beat_q;
  logic   ar_fire, r_fire, last;

  assign ar_ready_o = (state_q == st_idle);
  assign ar_fire    = ar_valid_i && ar_ready_o;
  assign r_fire     = r_valid_o && r_ready_i;
  assign last       = (beat_q == len_q);

  // The array answers in the same cycle, so the beat follows the address directly.
  assign rd_addr_o  = addr_q;
  assign r_valid_o  = (state_q == st_burst);
  assign r_o.id     = id_q;
  assign r_o.data   = rd_data_i;
  assign r_o.resp   = RespOkay;
  assign r_o.last   = last;

  // Beat index and state; the beat under back-pressure stays put.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      beat_q  <= '0;
    end else if (ar_fire) begin
      state_q <= st_burst;
      beat_q  <= '0;
    end else if (r_fire) begin
      if (last) begin
        state_q <= st_idle;
      end
      beat_q <= beat_q + len_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_q   <= ar_i.id;
      addr_q <= ar_i.addr;
      len_q  <= ar_i.len;
    end else if (r_fire) begin
      addr_q <= addr_q + addr_t'(1);
    end
  end

endmodule

// ==== mem_array.sv ====
// Word storage with one byte-masked write port and one combinational read port.
`timescale 1ns/1ps

module mem_array (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               wr_en_i,
  input  axi_mem_pkg::addr_t wr_addr_i,
  input  axi_mem_pkg::data_t wr_data_i,
  input  axi_mem_pkg::strb_t wr_strb_i,
  input  axi_mem_pkg::addr_t rd_addr_i,
  output axi_mem_pkg::data_t rd_data_o
);
  import axi_mem_pkg::*;

  data_t mem_q [MemDepth];

  // Every word starts out as zero after reset.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < MemDepth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      // Only the bytes with their strobe set change.
      for (int unsigned b = 0; b < StrbWidth; b++) begin
        if (wr_strb_i[b]) begin
          mem_q[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // A write in the same cycle lands at the clock edge, so the read sees the old word.
  assign rd_data_o = mem_q[rd_addr_i];

endmodule

// ==== atop_mem_top.sv ====
// Top level of the memory target, with the ATOP filter in front of the write and read engines.
`timescale 1ns/1ps

module atop_mem_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  axi_mem_pkg::axi_req_t req_i,
  output axi_mem_pkg::axi_rsp_t rsp_o
);
  import axi_mem_pkg::*;

  // Filtered port between the filter and the engines.
  axi_req_t mst_req;
  axi_rsp_t mst_rsp;

  // Engine-side halves of the filtered response.
  logic    aw_ready, w_ready, b_valid, ar_ready, r_valid;
  b_chan_t b;
  r_chan_t r;

  // Array ports.
  logic  wr_en;
  addr_t wr_addr, rd_addr;
  data_t wr_data, rd_data;
  strb_t wr_strb;

  axi_atop_filter u_filter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .slv_req_i (req_i),
    .slv_rsp_o (rsp_o),
    .mst_req_o (mst_req),
    .mst_rsp_i (mst_rsp)
  );

  assign mst_rsp = '{
    aw_ready: aw_ready,
    w_ready:  w_ready,
    b:        b,
    b_valid:  b_valid,
    ar_ready: ar_ready,
    r:        r,
    r_valid:  r_valid
  };

  mem_write_engine u_write (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_i       (mst_req.aw),
    .aw_valid_i (mst_req.aw_valid),
    .aw_ready_o (aw_ready),
    .w_i        (mst_req.w),
    .w_valid_i  (mst_req.w_valid),
    .w_ready_o  (w_ready),
    .b_o        (b),
    .b_valid_o  (b_valid),
    .b_ready_i  (mst_req.b_ready),
    .wr_en_o    (wr_en),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_strb_o  (wr_strb)
  );

  mem_read_engine u_read (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_i       (mst_req.ar),
    .ar_valid_i (mst_req.ar_valid),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_valid_o  (r_valid),
    .r_ready_i  (mst_req.r_ready),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data)
  );

  mem_array u_array (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .wr_strb_i (wr_strb),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

endmodule

// ==== tb_atop_checker.sv ====
// Testbench checker; mirrors the memory from observed writes and compares every B and R beat.
`timescale 1ns/1ps

module tb_atop_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  axi_mem_pkg::axi_req_t req_i,
  input  axi_mem_pkg::axi_rsp_t rsp_i,
  input  axi_mem_pkg::id_t      atom_id_i,
  input  int                    test_num_i,
  input  logic                  test_end_i,
  output int                    err_cnt_o,
  output int                    chk_cnt_o
);
  import axi_mem_pkg::*;

  // Memory model, updated only by ordinary W beats.
  data_t    model [MemDepth];
  // Expected B responses, one per accepted AW.
  b_chan_t  exp_b_q [$];
  // Accepted ordinary reads and the lengths of owed SLVERR bursts.
  ar_chan_t exp_ar_q [$];
  len_t     atom_r_q [$];
  logic     wr_atomic = 1'b0;
  addr_t    wr_addr = '0;
  int       rd_beat = 0;
  int       atom_beat = 0;
  int       err_total = 0;
  int       chk_total = 0;
  int       test_err = 0;
  int       test_chk = 0;
  logic     in_reset_q = 1'b0;

  assign err_cnt_o = err_total;
  assign chk_cnt_o = chk_total;

  function automatic string test_name(input int n);
    case (n)
      1: return "reset state";
      2: return "plain write and read back";
      3: return "atomic store";
      4: return "atomic load, swap and compare";
      5: return "random mix";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check(input logic ok, input string msg);
    chk_total++;
    test_chk++;
    if (!ok) begin
      err_total++;
      test_err++;
      $display("Error at time %0t: %s", $time, msg);
    end
  endtask

  // All ports are sampled at the rising edge, where the transfers of the past cycle are final.
  always @(posedge clk_i) begin
    b_chan_t  exp_b;
    ar_chan_t exp_ar;
    addr_t    idx;
    logic     end_burst;
    if (!rst_ni) begin
      foreach (model[i]) model[i] = '0;
      exp_b_q.delete();
      exp_ar_q.delete();
      atom_r_q.delete();
      rd_beat    = 0;
      atom_beat  = 0;
      wr_atomic  = 1'b0;
      in_reset_q = 1'b1;
    end else begin
      if (in_reset_q) begin
        check(!rsp_i.b_valid && !rsp_i.r_valid, "B or R valid high right after reset");
      end
      in_reset_q = 1'b0;

      // AW comes first, since an atomic W beat may pass in the same cycle.
      if (req_i.aw_valid && rsp_i.aw_ready) begin
        wr_atomic  = (req_i.aw.atop[5:4] != AtopNone);
        wr_addr    = req_i.aw.addr;
        exp_b.id   = req_i.aw.id;
        exp_b.resp = wr_atomic ? RespSlvErr : RespOkay;
        exp_b_q.push_back(exp_b);
        if (req_i.aw.atop[5:4] == AtopLoad || req_i.aw.atop[5:4] == AtopSwapCmp) begin
          atom_r_q.push_back(req_i.aw.len);
        end
      end

      if (req_i.w_valid && rsp_i.w_ready && !wr_atomic) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (req_i.w.strb[b]) begin
            model[wr_addr][8*b +: 8] = req_i.w.data[8*b +: 8];
          end
        end
        wr_addr = wr_addr + addr_t'(1);
      end

      if (rsp_i.b_valid && req_i.b_ready) begin
        if (exp_b_q.size() == 0) begin
          check(1'b0, "B response with no write outstanding");
        end else begin
          exp_b = exp_b_q.pop_front();
          check(rsp_i.b.id == exp_b.id && rsp_i.b.resp == exp_b.resp,
                $sformatf("B id %0h resp %0h, expected id %0h resp %0h",
                          rsp_i.b.id, rsp_i.b.resp, exp_b.id, exp_b.resp));
        end
      end

      if (req_i.ar_valid && rsp_i.ar_ready) begin
        exp_ar_q.push_back(req_i.ar);
      end

      // R beats are sorted by ID, as the reserved ID marks injected bursts.
      if (rsp_i.r_valid && req_i.r_ready) begin
        if (rsp_i.r.id == atom_id_i) begin
          if (atom_r_q.size() == 0) begin
            check(1'b0, "SLVERR R beat with no atomic load outstanding");
          end else begin
            end_burst = (atom_beat == int'(atom_r_q[0]));
            check(rsp_i.r.resp == RespSlvErr && rsp_i.r.data == '0 &&
                  rsp_i.r.last == end_burst,
                  $sformatf("atomic R beat %0d: resp %0h data %h last %b",
                            atom_beat, rsp_i.r.resp, rsp_i.r.data, rsp_i.r.last));
            if (rsp_i.r.last || end_burst) begin
              void'(atom_r_q.pop_front());
              atom_beat = 0;
            end else begin
              atom_beat++;
            end
          end
        end else if (exp_ar_q.size() == 0) begin
          check(1'b0, "R beat with no read outstanding");
        end else begin
          exp_ar    = exp_ar_q[0];
          idx       = exp_ar.addr + addr_t'(rd_beat);
          end_burst = (rd_beat == int'(exp_ar.len));
          check(rsp_i.r.id == exp_ar.id && rsp_i.r.resp == RespOkay &&
                rsp_i.r.data == model[idx] && rsp_i.r.last == end_burst,
                $sformatf("read of word %0h beat %0d: id %0h data %h last %b, expected %h",
                          idx, rd_beat, rsp_i.r.id, rsp_i.r.data, rsp_i.r.last, model[idx]));
          if (rsp_i.r.last || end_burst) begin
            void'(exp_ar_q.pop_front());
            rd_beat = 0;
          end else begin
            rd_beat++;
          end
        end
      end

      // Every burst of a test has been answered by the time the test ends.
      if (test_end_i) begin
        check(exp_b_q.size() == 0, "a write burst got no B response");
        check(exp_ar_q.size() == 0 && atom_r_q.size() == 0,
              "a read burst did not deliver all its beats");
        $display("test %0d, %s: %0d checks, %0d errors, %s", test_num_i,
                 test_name(test_num_i), test_chk, test_err,
                 (test_err == 0) ? "passed" : "failed");
        test_chk = 0;
        test_err = 0;
      end
    end
  end

endmodule

// ==== tb_atop_mem.sv ====
// Testbench top for the ATOP memory target; drives random AXI traffic and back-pressure into the DUT.
`timescale 1ns/1ps

module tb_atop_mem;
  import axi_mem_pkg::*;

  localparam int ClkPeriod = 100;
  localparam int NumTests  = 5;
  localparam int NumMix    = 120;
  // Bursts over all tests, where a write and a read each count as one.
  localparam int NumTxns   = 4 + 2 * 8 + 3 * 4 + 2 * 6 + 2 * NumMix;
  // Every burst may take up to 256 beats, with a margin of 4 cycles per beat.
  localparam int TimeoutCycles = NumTxns * 256 * 4;
  // Atomic bursts own the top ID; ordinary traffic never uses it.
  localparam id_t AtomId = 4'hf;

  logic     clk_i;
  logic     rst_ni;
  aw_chan_t drv_aw;
  logic     drv_aw_valid;
  w_chan_t  drv_w;
  logic     drv_w_valid;
  logic     drv_b_ready;
  ar_chan_t drv_ar;
  logic     drv_ar_valid;
  logic     drv_r_ready;
  axi_req_t req;
  axi_rsp_t rsp;
  int       test_num;
  logic     test_end;
  int       err_cnt;
  int       chk_cnt;

  // Stimulus and back-pressure step separate LFSRs, so neither disturbs the other.
  logic [31:0] stim_lfsr = 32'hf37cb222;
  logic [31:0] bp_lfsr   = 32'hf37cb222;

  assign req = '{
    aw:       drv_aw,
    aw_valid: drv_aw_valid,
    w:        drv_w,
    w_valid:  drv_w_valid,
    b_ready:  drv_b_ready,
    ar:       drv_ar,
    ar_valid: drv_ar_valid,
    r_ready:  drv_r_ready
  };

  atop_mem_top DUT (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req),
    .rsp_o  (rsp)
  );

  tb_atop_checker u_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req),
    .rsp_i      (rsp),
    .atom_id_i  (AtomId),
    .test_num_i (test_num),
    .test_end_i (test_end),
    .err_cnt_o  (err_cnt),
    .chk_cnt_o  (chk_cnt)
  );

  // Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step for every bit taken.
  function automatic logic [31:0] stim_rand(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[31]};
    end
    return v;
  endfunction

  function automatic logic bp_bit();
    bp_lfsr = lfsr_next(bp_lfsr);
    return bp_lfsr[31];
  endfunction

  function automatic id_t random_id();
    return id_t'(stim_rand(4) % 15);
  endfunction

  // Half of the bursts are short, the rest span the full length range.
  function automatic len_t random_len();
    if (stim_rand(1) != 0) begin
      return len_t'(stim_rand(8));
    end
    return len_t'(stim_rand(3));
  endfunction

  task automatic send_aw(input aw_chan_t aw);
    drv_aw       <= aw;
    drv_aw_valid <= 1'b1;
    do @(posedge clk_i); while (!rsp.aw_ready);
    drv_aw_valid <= 1'b0;
  endtask

  task automatic send_w(input len_t len);
    w_chan_t beat;
    for (int i = 0; i <= int'(len); i++) begin
      beat.data = data_t'(stim_rand(32));
      beat.strb = strb_t'(stim_rand(4));
      beat.last = (i == int'(len));
      drv_w       <= beat;
      drv_w_valid <= 1'b1;
      do @(posedge clk_i); while (!rsp.w_ready);
    end
    drv_w_valid <= 1'b0;
  endtask

  task automatic send_ar(input ar_chan_t ar);
    drv_ar       <= ar;
    drv_ar_valid <= 1'b1;
    do @(posedge clk_i); while (!rsp.ar_ready);
    drv_ar_valid <= 1'b0;
  endtask

  // Only one write is in flight, so the next B belongs to it.
  task automatic wait_b();
    do @(posedge clk_i); while (!(rsp.b_valid && drv_b_ready));
  endtask

  task automatic wait_r_last(input id_t id);
    do @(posedge clk_i);
    while (!(rsp.r_valid && drv_r_ready && rsp.r.last && rsp.r.id == id));
  endtask

  // AW and W run side by side; loads, swaps and compares also wait for their R burst.
  // The B wait follows the last W beat, since an atomic B may come before its R burst ends.
  task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                             input atop_t atop);
    fork
      send_aw('{id: id, addr: addr, len: len, atop: atop});
      begin
        send_w(len);
        wait_b();
      end
      if (atop[5:4] == AtopLoad || atop[5:4] == AtopSwapCmp) wait_r_last(id);
    join
  endtask

  task automatic read_burst(input id_t id, input addr_t addr, input len_t len);
    fork
      send_ar('{id: id, addr: addr, len: len});
      wait_r_last(id);
    join
  endtask

  // The checker prints the test line on the edge where it sees the end strobe.
  task automatic finish_test(input int n);
    test_num <= n;
    test_end <= 1'b1;
    @(posedge clk_i);
    test_end <= 1'b0;
    @(posedge clk_i);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Ready signals drop about a quarter of the time.
  initial begin
    drv_b_ready <= 1'b0;
    drv_r_ready <= 1'b0;
    forever begin
      @(posedge clk_i);
      drv_b_ready <= bp_bit() | bp_bit();
      drv_r_ready <= bp_bit() | bp_bit();
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d clock cycles.", TimeoutCycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    id_t        rid;
    addr_t      addr;
    addr_t      raddr;
    len_t       len;
    len_t       rlen;
    atop_t      atop;
    logic [1:0] kind;
    drv_aw       <= '0;
    drv_aw_valid <= 1'b0;
    drv_w        <= '0;
    drv_w_valid  <= 1'b0;
    drv_ar       <= '0;
    drv_ar_valid <= 1'b0;
    test_num     <= 0;
    test_end     <= 1'b0;
    rst_ni       <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Freshly reset memory reads as zero.
    repeat (4) read_burst(random_id(), addr_t'(stim_rand(8)), len_t'(stim_rand(4)));
    finish_test(1);

    repeat (8) begin
      rid  = random_id();
      addr = addr_t'(stim_rand(8));
      len  = random_len();
      write_burst(rid, addr, len, '0);
      read_burst(random_id(), addr, len);
    end
    finish_test(2);

    // An atomic store over written data must leave the words as they were.
    repeat (4) begin
      addr = addr_t'(stim_rand(8));
      len  = random_len();
      write_burst(random_id(), addr, len, '0);
      write_burst(AtomId, addr, len, {AtopStore, 4'(stim_rand(4))});
      read_burst(random_id(), addr, len);
    end
    finish_test(3);

    repeat (6) begin
      rid  = random_id();
      addr = addr_t'(stim_rand(8));
      len  = random_len();
      atop = {(stim_rand(1) != 0) ? AtopSwapCmp : AtopLoad, 4'(stim_rand(4))};
      fork
        write_burst(AtomId, addr, len, atop);
        read_burst(rid, addr, len);
      join
    end
    finish_test(4);

    repeat (NumMix) begin
      kind  = 2'(stim_rand(2));
      rid   = random_id();
      addr  = addr_t'(stim_rand(8));
      len   = random_len();
      raddr = addr_t'(stim_rand(8));
      rlen  = random_len();
      case (kind)
        2'd0: write_burst(rid, addr, len, '0);
        2'd1: read_burst(rid, addr, len);
        2'd2: write_burst(AtomId, addr, len, {AtopStore, 4'(stim_rand(4))});
        default: begin
          atop = {(stim_rand(1) != 0) ? AtopSwapCmp : AtopLoad, 4'(stim_rand(4))};
          fork
            write_burst(AtomId, addr, len, atop);
            read_burst(rid, raddr, rlen);
          join
        end
      endcase
    end
    finish_test(5);

    $display("%0d tests, %0d checks, %0d errors", NumTests, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
axi_mem_pkg.sv
axi_atop_filter.sv
mem_write_engine.sv
mem_read_engine.sv
mem_array.sv
atop_mem_top.sv
tb_atop_checker.sv
tb_atop_mem.sv

// ==== Makefile ====
# Verilator build and run for the ATOP memory target testbench.

VERILATOR ?= verilator
TOP       ?= tb_atop_mem
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test OK

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
